/* src/kyber_consts.svh */
`ifndef KYBER_CONSTS_SVH
`define KYBER_CONSTS_SVH

// coefficients per polynomial
`define KYBER_N 256

// width of one coefficient
`define COEF_W 12

// bus word width
`define WORD_W 32

// the public seed is 256 bits, sent as this many bus words
`define SEED_WORDS 8

// output FIFO depth, the largest frame is 4*96 + 8 = 392 words
`define TX_DEPTH 512

// input FIFO depth, the backlog grows by a quarter word per cycle
// at most, so a k=4 frame stays well under this
`define RX_DEPTH 128

`endif

/* src/kyber_pkg.sv */
`include "kyber_consts.svh"

package kyber_pkg;

	// one polynomial coefficient
	typedef logic [`COEF_W-1:0] coef_t;

	// two coefficients, the lower one in bits 11..0
	typedef logic [2*`COEF_W-1:0] coef_pair_t;

	// security parameter as given on start
	typedef logic [2:0] k_t;

	// frame length in bus words, k*96 at most 384
	typedef logic [8:0] frame_cnt_t;

endpackage

/* src/link_pkg.sv */
`include "kyber_consts.svh"

package link_pkg;

	typedef logic [`WORD_W-1:0] word_t;

	typedef logic [`SEED_WORDS*`WORD_W-1:0] seed_t;

	typedef logic [$clog2(`TX_DEPTH)-1:0] tx_addr_t;

	typedef logic [$clog2(`RX_DEPTH)-1:0] rx_addr_t;

	// transmitter FSM, SEND holds until the next start
	typedef enum logic [1:0] {
		IDLE,
		FILL,
		SEED,
		SEND
	} tx_state_e;

endpackage

/* src/session_if.sv */
`timescale 1ns/10ps

interface session_if;

	// frame length in packed words, k*96
	kyber_pkg::frame_cnt_t frame_words;

	// lowest word of the seed register
	link_pkg::word_t seed_word;

	// one cycle after start
	logic new_frame;

	// moves the seed register on by one word
	logic seed_rot;

	modport regs (
		output frame_words,
		output seed_word,
		output new_frame,
		input  seed_rot
	);

	modport tx (
		input  frame_words,
		input  seed_word,
		input  new_frame,
		output seed_rot
	);

endinterface

/* src/session_regs.sv */
`timescale 1ns/10ps
`include "kyber_consts.svh"

module session_regs (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  kyber_pkg::k_t         k,
	input  logic                  seed_wen,
	input  link_pkg::word_t       seed_din,
	session_if.regs               sess,
	output kyber_pkg::frame_cnt_t frame_words
);

	localparam int POLY_WORDS = `KYBER_N * `COEF_W / `WORD_W;
	localparam int SEED_BITS = `SEED_WORDS * `WORD_W;

	kyber_pkg::k_t   k_q;
	logic            new_frame_q;
	link_pkg::seed_t seed_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			k_q <= 3'd4;
			new_frame_q <= 1'b0;
		end else begin
			new_frame_q <= start;
			if (start)
				k_q <= k;
		end
	end

	// anything other than 2 or 3 is treated as k=4
	always_comb begin
		case (k_q)
			3'd2:    frame_words = kyber_pkg::frame_cnt_t'(2 * POLY_WORDS);
			3'd3:    frame_words = kyber_pkg::frame_cnt_t'(3 * POLY_WORDS);
			default: frame_words = kyber_pkg::frame_cnt_t'(4 * POLY_WORDS);
		endcase
	end

	// words enter at the top so the first one loaded ends up lowest
	always_ff @(posedge clk) begin
		if (seed_wen)
			seed_q <= {seed_din, seed_q[SEED_BITS-1:`WORD_W]};
		else if (sess.seed_rot)
			seed_q <= {seed_q[`WORD_W-1:0], seed_q[SEED_BITS-1:`WORD_W]};
	end

	assign sess.seed_word = seed_q[`WORD_W-1:0];
	assign sess.frame_words = frame_words;
	assign sess.new_frame = new_frame_q;

endmodule

/* src/coef_packer.sv */
`timescale 1ns/10ps

module coef_packer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  logic                  pair_wen,
	input  kyber_pkg::coef_pair_t pair_din,
	output logic                  pk_wen,
	output link_pkg::word_t       pk_word
);

	// four pairs make 96 bits, which leave as three words
	logic [1:0]            phase;
	kyber_pkg::coef_pair_t resid;

	always_ff @(posedge clk) begin
		if (rst || start) begin
			phase <= 2'd0;
			pk_wen <= 1'b0;
		end else begin
			pk_wen <= pair_wen && (phase != 2'd0);
			if (pair_wen)
				phase <= phase + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			resid <= '0;
		end else if (pair_wen) begin
			case (phase)
				2'd0: begin
					resid <= pair_din;
				end
				2'd1: begin
					pk_word <= {pair_din[7:0], resid};
					resid <= {8'd0, pair_din[23:8]};
				end
				2'd2: begin
					pk_word <= {pair_din[15:0], resid[15:0]};
					resid <= {16'd0, pair_din[23:16]};
				end
				default: begin
					// residue is down to 8 bits, so this pair closes the word exactly
					pk_word <= {pair_din, resid[7:0]};
					resid <= '0;
				end
			endcase
		end
	end

endmodule

/* src/coef_unpacker.sv */
`timescale 1ns/10ps
`include "kyber_consts.svh"

module coef_unpacker (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  kyber_pkg::frame_cnt_t frame_words,
	input  logic                  wen,
	input  link_pkg::word_t       din,
	output logic                  req_c,
	output logic                  ct_valid,
	output kyber_pkg::coef_pair_t ct_pair
);

	localparam int PAIR_W = 2 * `COEF_W;
	localparam int BUF_W = PAIR_W + `WORD_W;
	localparam int CNT_W = $clog2(BUF_W + 1);

	link_pkg::word_t          mem [`RX_DEPTH];
	link_pkg::rx_addr_t       wr_ptr;
	link_pkg::rx_addr_t       rd_ptr;
	logic [$clog2(`RX_DEPTH):0] fill;
	kyber_pkg::frame_cnt_t    acc_cnt;
	logic [BUF_W-1:0]         sbuf_q;
	logic [BUF_W-1:0]         sbuf_d;
	logic [CNT_W-1:0]         cnt_q;
	logic [CNT_W-1:0]         cnt_d;
	logic [CNT_W-1:0]         eff;
	logic                     accept;
	logic                     take;
	logic                     pop;
	kyber_pkg::coef_t         lo_c;
	kyber_pkg::coef_t         hi_c;

	assign accept = wen && req_c;
	assign take = cnt_q >= CNT_W'(PAIR_W);

	// the pair leaves first, then a word is popped if the rest leaves 32 bits of room
	always_comb begin
		eff = take ? cnt_q - CNT_W'(PAIR_W) : cnt_q;
		pop = (fill != '0) && (eff <= CNT_W'(BUF_W - `WORD_W));
		sbuf_d = take ? (sbuf_q >> PAIR_W) : sbuf_q;
		if (pop)
			sbuf_d = sbuf_d | ({{(BUF_W - `WORD_W){1'b0}}, mem[rd_ptr]} << eff);
		cnt_d = pop ? eff + CNT_W'(`WORD_W) : eff;
	end

	always_ff @(posedge clk) begin
		if (accept)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst || start) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			acc_cnt <= '0;
		end else begin
			if (accept) begin
				wr_ptr <= wr_ptr + 1'b1;
				acc_cnt <= acc_cnt + 9'd1;
			end
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (accept && !pop)
				fill <= fill + 1'b1;
			else if (!accept && pop)
				fill <= fill - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			req_c <= 1'b0;
		else if (start)
			req_c <= 1'b1;
		else if (accept && acc_cnt == frame_words - 9'd1)
			req_c <= 1'b0;
	end

	// bits above cnt_q must stay zero for the OR merge above
	always_ff @(posedge clk) begin
		if (rst || start) begin
			sbuf_q <= '0;
			cnt_q <= '0;
			ct_valid <= 1'b0;
		end else begin
			sbuf_q <= sbuf_d;
			cnt_q <= cnt_d;
			ct_valid <= take;
		end
	end

	assign lo_c = sbuf_q[`COEF_W-1:0];
	assign hi_c = sbuf_q[PAIR_W-1:`COEF_W];

	always_ff @(posedge clk) begin
		if (take)
			ct_pair <= {hi_c, lo_c};
	end

endmodule

/* src/pk_tx_ctrl.sv */
`timescale 1ns/10ps
`include "kyber_consts.svh"

module pk_tx_ctrl (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	session_if.tx           sess,
	input  logic            pk_wen,
	input  link_pkg::word_t pk_word,
	input  logic            req_pk,
	output logic            ready_pk,
	output logic            valid,
	output link_pkg::word_t dout
);

	localparam int SEED_CW = $clog2(`SEED_WORDS);

	link_pkg::tx_state_e   state;
	link_pkg::tx_state_e   state_d;
	link_pkg::word_t       mem [`TX_DEPTH];
	link_pkg::tx_addr_t    wr_ptr;
	link_pkg::tx_addr_t    rd_ptr;
	kyber_pkg::frame_cnt_t fill_cnt;
	logic [SEED_CW-1:0]    seed_cnt;
	logic                  last_pk;
	logic                  fifo_wen;
	link_pkg::word_t       fifo_din;
	logic                  pop;

	assign last_pk = pk_wen && (fill_cnt == sess.frame_words - 9'd1);

	always_comb begin
		state_d = state;
		case (state)
			link_pkg::IDLE: begin
				if (sess.new_frame)
					state_d = link_pkg::FILL;
			end
			link_pkg::FILL: begin
				if (last_pk)
					state_d = link_pkg::SEED;
			end
			link_pkg::SEED: begin
				if (seed_cnt == SEED_CW'(`SEED_WORDS - 1))
					state_d = link_pkg::SEND;
			end
			default: begin
				state_d = state;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || start)
			state <= link_pkg::IDLE;
		else
			state <= state_d;
	end

	// the seed goes out lowest word first and rotates, so it is whole again afterwards
	assign sess.seed_rot = (state == link_pkg::SEED);
	assign fifo_wen = (state == link_pkg::FILL && pk_wen) || state == link_pkg::SEED;
	assign fifo_din = (state == link_pkg::SEED) ? sess.seed_word : pk_word;

	assign ready_pk = (state == link_pkg::SEND);
	assign pop = req_pk && ready_pk && (rd_ptr != wr_ptr);

	always_ff @(posedge clk) begin
		if (rst || start) begin
			fill_cnt <= '0;
			seed_cnt <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (state == link_pkg::FILL && pk_wen)
				fill_cnt <= fill_cnt + 9'd1;
			if (state == link_pkg::SEED)
				seed_cnt <= seed_cnt + 1'b1;
			if (fifo_wen)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_wen)
			mem[wr_ptr] <= fifo_din;
	end

	always_ff @(posedge clk) begin
		if (pop)
			dout <= mem[rd_ptr];
	end

	// a pop in the start cycle must not show up after ready_pk has dropped
	always_ff @(posedge clk) begin
		if (rst || start)
			valid <= 1'b0;
		else
			valid <= pop;
	end

endmodule

/* src/kyber_link_top.sv */
`timescale 1ns/10ps

module kyber_link_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  kyber_pkg::k_t         k,
	input  logic                  seed_wen,
	input  link_pkg::word_t       seed_din,
	input  logic                  pair_wen,
	input  kyber_pkg::coef_pair_t pair_din,
	input  logic                  req_pk,
	output logic                  ready_pk,
	output logic                  valid,
	output link_pkg::word_t       dout,
	output logic                  req_c,
	input  logic                  wen,
	input  link_pkg::word_t       din,
	output logic                  ct_valid,
	output kyber_pkg::coef_pair_t ct_pair
);

	logic                  pk_wen;
	link_pkg::word_t       pk_word;
	kyber_pkg::frame_cnt_t frame_words;

	session_if sess_i ();

	session_regs regs_i (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.k           (k),
		.seed_wen    (seed_wen),
		.seed_din    (seed_din),
		.sess        (sess_i.regs),
		.frame_words (frame_words)
	);

	coef_packer packer_i (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.pair_wen (pair_wen),
		.pair_din (pair_din),
		.pk_wen   (pk_wen),
		.pk_word  (pk_word)
	);

	pk_tx_ctrl tx_i (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.sess     (sess_i.tx),
		.pk_wen   (pk_wen),
		.pk_word  (pk_word),
		.req_pk   (req_pk),
		.ready_pk (ready_pk),
		.valid    (valid),
		.dout     (dout)
	);

	coef_unpacker unpacker_i (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.frame_words (frame_words),
		.wen         (wen),
		.din         (din),
		.req_c       (req_c),
		.ct_valid    (ct_valid),
		.ct_pair     (ct_pair)
	);

endmodule

/* test/tb_kyber_ref.svh */
`ifndef TB_KYBER_REF_SVH
`define TB_KYBER_REF_SVH

// one step of the 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// k values other than 2 and 3 count as 4
function automatic int effective_k(input kyber_pkg::k_t kv);
	if (kv == 3'd2 || kv == 3'd3)
		return int'(kv);
	return 4;
endfunction

// the stream is little-endian, so bit b lives in pair b/24 at position b%24
function automatic link_pkg::word_t pack_word(input kyber_pkg::coef_pair_t pairs [$],
		input int idx);
	link_pkg::word_t w;
	int              b;
	int              j;
	w = '0;
	for (j = 0; j < `WORD_W; j++) begin
		b = idx * `WORD_W + j;
		w[j] = pairs[b / (2 * `COEF_W)][b % (2 * `COEF_W)];
	end
	return w;
endfunction

// the reverse view of the same stream, words low first
function automatic kyber_pkg::coef_pair_t unpack_pair(input link_pkg::word_t words [$],
		input int idx);
	kyber_pkg::coef_pair_t p;
	int                    b;
	int                    j;
	p = '0;
	for (j = 0; j < 2 * `COEF_W; j++) begin
		b = idx * 2 * `COEF_W + j;
		p[j] = words[b / `WORD_W][b % `WORD_W];
	end
	return p;
endfunction

`endif

/* test/tb_kyber_link.sv */
`timescale 1ns/10ps
`include "kyber_consts.svh"

module tb_kyber_link;

	localparam int CLK_HALF = 50;
	localparam int RST_CYCLES = 8;
	// a k=4 session needs about 1500 cycles and the run holds five sessions at most
	localparam int SESSION_MAX = 1500;
	localparam int MAX_CYCLES = 5 * SESSION_MAX + 500;

	logic                  clk;
	logic                  rst;
	logic                  start;
	kyber_pkg::k_t         k;
	logic                  seed_wen;
	link_pkg::word_t       seed_din;
	logic                  pair_wen;
	kyber_pkg::coef_pair_t pair_din;
	logic                  req_pk;
	logic                  ready_pk;
	logic                  valid;
	link_pkg::word_t       dout;
	logic                  req_c;
	logic                  wen;
	link_pkg::word_t       din;
	logic                  ct_valid;
	kyber_pkg::coef_pair_t ct_pair;

	link_pkg::word_t       exp_words [$];
	kyber_pkg::coef_pair_t exp_pairs [$];
	logic [31:0]           rng_state;
	int                    err_cnt;
	int                    check_cnt;
	int                    test_cnt;
	int                    test_err_base;
	int                    cycle_cnt;

	`include "tb_kyber_ref.svh"

	kyber_link_top dut_i (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.k        (k),
		.seed_wen (seed_wen),
		.seed_din (seed_din),
		.pair_wen (pair_wen),
		.pair_din (pair_din),
		.req_pk   (req_pk),
		.ready_pk (ready_pk),
		.valid    (valid),
		.dout     (dout),
		.req_c    (req_c),
		.wen      (wen),
		.din      (din),
		.ct_valid (ct_valid),
		.ct_pair  (ct_pair)
	);

	always #CLK_HALF clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	// outputs settle after the rising edge, so they are checked on the falling one
	always @(negedge clk) begin : compare
		link_pkg::word_t       exp_w;
		kyber_pkg::coef_pair_t exp_p;
		if (!rst && valid) begin
			check_cnt++;
			assert (ready_pk)
			else begin
				$display("valid came while ready_pk was low at %0t", $time);
				err_cnt++;
			end
			assert (exp_words.size() != 0)
			else begin
				$display("a word came out on dout when none was expected at %0t", $time);
				err_cnt++;
			end
			if (exp_words.size() != 0) begin
				exp_w = exp_words.pop_front();
				assert (dout == exp_w)
				else begin
					$display("[ERROR] %0t: dout is %h, expected %h", $time, dout, exp_w);
					err_cnt++;
				end
			end
		end
		if (!rst && ct_valid) begin
			check_cnt++;
			assert (exp_pairs.size() != 0)
			else begin
				$display("a pair came out on ct_pair when none was expected at %0t", $time);
				err_cnt++;
			end
			if (exp_pairs.size() != 0) begin
				exp_p = exp_pairs.pop_front();
				assert (ct_pair == exp_p)
				else begin
					$display("[ERROR] %0t: ct_pair is %h, expected %h", $time, ct_pair, exp_p);
					err_cnt++;
				end
			end
		end
	end

	function automatic link_pkg::word_t rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic end_test(input string name);
		test_cnt++;
		$display("%s: %0d errors", name, err_cnt - test_err_base);
		test_err_base = err_cnt;
	endtask

	task automatic check_idle(input int n);
		repeat (n) begin
			check_cnt++;
			assert (!ready_pk && !valid && !req_c)
			else begin
				$display("an output rose before the first start at %0t", $time);
				err_cnt++;
			end
			@(negedge clk);
		end
	endtask

	task automatic begin_session(input kyber_pkg::k_t kv);
		start = 1'b1;
		k = kv;
		@(negedge clk);
		start = 1'b0;
		check_cnt++;
		assert (!ready_pk && req_c)
		else begin
			$display("start did not drop ready_pk and raise req_c at %0t", $time);
			err_cnt++;
		end
	endtask

	// the seed goes in first, then the pairs back to back
	task automatic send_pk_frame(input int n_pairs, input logic expect_out);
		kyber_pkg::coef_pair_t pairs [$];
		link_pkg::word_t       seeds [$];
		link_pkg::word_t       w;
		int                    i;
		for (i = 0; i < `SEED_WORDS; i++) begin
			w = rand_word();
			seeds.push_back(w);
			seed_wen = 1'b1;
			seed_din = w;
			@(negedge clk);
		end
		seed_wen = 1'b0;
		for (i = 0; i < n_pairs; i++) begin
			w = rand_word();
			pairs.push_back(w[2*`COEF_W-1:0]);
		end
		if (expect_out) begin
			for (i = 0; i < n_pairs * 2 * `COEF_W / `WORD_W; i++)
				exp_words.push_back(pack_word(pairs, i));
			for (i = 0; i < `SEED_WORDS; i++)
				exp_words.push_back(seeds[i]);
		end
		for (i = 0; i < n_pairs; i++) begin
			pair_wen = 1'b1;
			pair_din = pairs[i];
			@(negedge clk);
		end
		pair_wen = 1'b0;
	endtask

	task automatic pull_pk_frame();
		while (!ready_pk)
			@(negedge clk);
		while (exp_words.size() != 0)
			@(posedge clk);
		repeat (4) @(negedge clk);
		check_cnt++;
		assert (ready_pk)
		else begin
			$display("ready_pk dropped before the next start at %0t", $time);
			err_cnt++;
		end
	endtask

	task automatic send_ct_words(input int n_send, input int frame);
		link_pkg::word_t words [$];
		int              accepted;
		int              n_acc;
		int              i;
		accepted = 0;
		n_acc = (n_send < frame) ? n_send : frame;
		for (i = 0; i < n_send; i++)
			words.push_back(rand_word());
		for (i = 0; i < n_acc * `WORD_W / (2 * `COEF_W); i++)
			exp_pairs.push_back(unpack_pair(words, i));
		for (i = 0; i < n_send; i++) begin
			if (req_c)
				accepted++;
			wen = 1'b1;
			din = words[i];
			@(negedge clk);
		end
		wen = 1'b0;
		check_cnt++;
		assert (accepted == n_acc && req_c == (n_send < frame))
		else begin
			$display("[ERROR] %0t: req_c let %0d words in, expected %0d", $time, accepted, n_acc);
			err_cnt++;
		end
		while (exp_pairs.size() != 0)
			@(posedge clk);
		repeat (8) @(negedge clk);
	endtask

	task automatic run_session(input kyber_pkg::k_t kv);
		int kk;
		kk = effective_k(kv);
		begin_session(kv);
		send_pk_frame(kk * `KYBER_N / 2, 1'b1);
		pull_pk_frame();
		end_test($sformatf("public key frame, k=%0d", kv));
		send_ct_words(kk * 96 + 4, kk * 96);
		end_test($sformatf("ciphertext unpacking, k=%0d", kv));
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		k = 3'd0;
		seed_wen = 1'b0;
		seed_din = '0;
		pair_wen = 1'b0;
		pair_din = '0;
		req_pk = 1'b0;
		wen = 1'b0;
		din = '0;
		rng_state = 32'hcf4;
		err_cnt = 0;
		check_cnt = 0;
		test_cnt = 0;
		test_err_base = 0;
		cycle_cnt = 0;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		check_idle(5);
		end_test("outputs idle after reset");
		// held from here on, so any valid must wait for ready_pk
		req_pk = 1'b1;
		run_session(3'd2);
		run_session(3'd3);
		run_session(3'd4);
		// a partial session leaves the packer and unpacker mid-word before the restart
		begin_session(3'd5);
		send_pk_frame(101, 1'b0);
		send_ct_words(31, 384);
		check_cnt++;
		assert (!ready_pk && req_c)
		else begin
			$display("partial session changed ready_pk or req_c at %0t", $time);
			err_cnt++;
		end
		end_test("partial session before restart, k=5");
		run_session(3'd5);
		$display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* compile.f */
+incdir+src
+incdir+test
src/kyber_pkg.sv
src/link_pkg.sv
src/session_if.sv
src/session_regs.sv
src/coef_packer.sv
src/coef_unpacker.sv
src/pk_tx_ctrl.sv
src/kyber_link_top.sv
test/tb_kyber_link.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_kyber_link
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
SIM       ?= $(OBJ_DIR)/V$(TOP)

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
